//--- design/rv_exec_macros.svh
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// Data word width
`define RV_XLEN 32

// Major opcodes
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_BRANCH  7'b1100011

// funct7 values
`define RV_F7_BASE     7'b0000000
`define RV_F7_ALT      7'b0100000
`define RV_F7_MULDIV   7'b0000001

// One iteration per result bit
`define RV_MULDIV_STEPS 32

`endif

//--- design/rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_macros.svh"

package rv_exec_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Branch offset bits are scattered around the register fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        j_fmt_t j;
    } rv_instr_t;

    typedef enum logic [3:0] {
        CLASS_ALU, CLASS_LUI, CLASS_AUIPC, CLASS_JAL,
        CLASS_JALR, CLASS_BRANCH, CLASS_MULDIV, CLASS_ILLEGAL
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // Encoded as funct3
    typedef enum logic [2:0] {
        MD_MUL, MD_MULH, MD_MULHSU, MD_MULHU,
        MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } md_op_e;

endpackage

`default_nettype wire

//--- design/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_decoder (
    input  wire rv_exec_pkg::rv_instr_t instr,
    output rv_exec_pkg::op_class_e      op_class,
    output rv_exec_pkg::alu_op_e        alu_op,
    output logic                        alu_use_imm,
    output logic [`RV_XLEN-1:0]         imm_i,
    output logic [`RV_XLEN-1:0]         imm_u,
    output logic [`RV_XLEN-1:0]         imm_b,
    output logic [`RV_XLEN-1:0]         imm_j
);
    import rv_exec_pkg::*;

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       f7_alt;

    assign opcode = instr.r.opcode;
    assign f3     = instr.r.funct3;
    assign f7     = instr.r.funct7;
    assign f7_alt = (f7 == `RV_F7_ALT);

    // Immediates, each through its own format view
    assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
    assign imm_u = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0};
    assign imm_b = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                    instr.b.imm4_1, 1'b0};
    assign imm_j = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                    instr.j.imm10_1, 1'b0};

    assign alu_use_imm = (opcode == `RV_OPC_OP_IMM);

    always_comb begin
        case (f3)
            3'd0:    alu_op = (!alu_use_imm && f7_alt) ? ALU_SUB : ALU_ADD;
            3'd1:    alu_op = ALU_SLL;
            3'd2:    alu_op = ALU_SLT;
            3'd3:    alu_op = ALU_SLTU;
            3'd4:    alu_op = ALU_XOR;
            3'd5:    alu_op = f7_alt ? ALU_SRA : ALU_SRL;
            3'd6:    alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        op_class = CLASS_ILLEGAL;
        case (opcode)
            `RV_OPC_OP: begin
                if (f7 == `RV_F7_MULDIV)
                    op_class = CLASS_MULDIV;
                else if (f7 == `RV_F7_BASE || (f7_alt && (f3 == 3'd0 || f3 == 3'd5)))
                    op_class = CLASS_ALU;
            end
            `RV_OPC_OP_IMM: begin
                // Shift immediates keep funct7 in the upper imm bits
                if (!(f3 == 3'd1 && f7 != `RV_F7_BASE) &&
                    !(f3 == 3'd5 && f7 != `RV_F7_BASE && !f7_alt))
                    op_class = CLASS_ALU;
            end
            `RV_OPC_LUI:    op_class = CLASS_LUI;
            `RV_OPC_AUIPC:  op_class = CLASS_AUIPC;
            `RV_OPC_JAL:    op_class = CLASS_JAL;
            `RV_OPC_JALR:   op_class = (f3 == 3'd0) ? CLASS_JALR : CLASS_ILLEGAL;
            `RV_OPC_BRANCH: op_class = CLASS_BRANCH;
            default:        op_class = CLASS_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_alu (
    input  wire rv_exec_pkg::alu_op_e alu_op,
    input  wire  [`RV_XLEN-1:0]       a,
    input  wire  [`RV_XLEN-1:0]       b,
    output logic [`RV_XLEN-1:0]       result
);
    import rv_exec_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            // Sign fill from bit 31
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_branch_unit (
    input  wire  [2:0]                  funct3,
    input  wire  [`RV_XLEN-1:0]         rs1_data,
    input  wire  [`RV_XLEN-1:0]         rs2_data,
    input  wire  [`RV_XLEN-1:0]         pc,
    input  wire  [`RV_XLEN-1:0]         imm_b,
    input  wire  [`RV_XLEN-1:0]         imm_j,
    input  wire  [`RV_XLEN-1:0]         imm_i,
    input  wire rv_exec_pkg::op_class_e op_class,
    output logic                        taken,
    output logic [`RV_XLEN-1:0]         target,
    output logic                        bad_cond
);
    import rv_exec_pkg::*;

    logic eq;
    logic lt;
    logic ltu;
    logic [`RV_XLEN-1:0] jalr_sum;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    // funct3 2 and 3 are unused encodings
    assign bad_cond = (funct3[2:1] == 2'b01);

    always_comb begin
        case (funct3)
            3'd0:    taken = eq;
            3'd1:    taken = !eq;
            3'd4:    taken = lt;
            3'd5:    taken = !lt;
            3'd6:    taken = ltu;
            3'd7:    taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_data + imm_i;

    always_comb begin
        case (op_class)
            CLASS_JAL:  target = pc + imm_j;
            CLASS_JALR: target = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            default:    target = pc + imm_b;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_muldiv.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_muldiv (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,
    input  wire rv_exec_pkg::md_op_e md_op,
    input  wire  [`RV_XLEN-1:0]      rs1_data,
    input  wire  [`RV_XLEN-1:0]      rs2_data,
    output logic                     done,
    output logic [`RV_XLEN-1:0]      result
);
    import rv_exec_pkg::*;

    localparam int XW    = `RV_XLEN;
    localparam int CNT_W = $clog2(`RV_MULDIV_STEPS);

    logic             busy;
    logic [CNT_W-1:0] cnt;

    md_op_e           op_q;
    logic             neg_q;
    logic             div_zero_q;
    logic [XW-1:0]    mag_b;
    logic [XW-1:0]    hi;
    logic [XW-1:0]    lo;

    logic             a_signed;
    logic             b_signed;
    logic             a_neg;
    logic             b_neg;
    logic             is_rem;

    logic [XW:0]      mul_sum;
    logic [XW:0]      div_shift;
    logic [XW:0]      div_diff;

    logic [2*XW-1:0]  prod;
    logic [2*XW-1:0]  prod_s;
    logic [XW-1:0]    quo;
    logic [XW-1:0]    rem;

    // Operand signedness from the operation
    assign a_signed = (md_op != MD_MULHU) && (md_op != MD_DIVU) && (md_op != MD_REMU);
    assign b_signed = a_signed && (md_op != MD_MULHSU);
    assign a_neg    = a_signed && rs1_data[XW-1];
    assign b_neg    = b_signed && rs2_data[XW-1];
    assign is_rem   = (md_op[2:1] == 2'b11);

    // Shift-add step, hi:lo holds the partial product
    assign mul_sum = {1'b0, hi} + (lo[0] ? {1'b0, mag_b} : {(XW+1){1'b0}});

    // Restoring step, hi is the remainder and lo collects quotient bits
    assign div_shift = {hi, lo[XW-1]};
    assign div_diff  = div_shift - {1'b0, mag_b};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(`RV_MULDIV_STEPS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q       <= md_op;
            neg_q      <= is_rem ? a_neg : (a_neg ^ b_neg);
            div_zero_q <= (rs2_data == '0);
            mag_b      <= b_neg ? -rs2_data : rs2_data;
            hi         <= '0;
            lo         <= a_neg ? -rs1_data : rs1_data;
        end else if (busy) begin
            if (op_q[2]) begin
                if (!div_diff[XW]) begin
                    hi <= div_diff[XW-1:0];
                    lo <= {lo[XW-2:0], 1'b1};
                end else begin
                    hi <= div_shift[XW-1:0];
                    lo <= {lo[XW-2:0], 1'b0};
                end
            end else begin
                {hi, lo} <= {mul_sum, lo[XW-1:1]};
            end
        end
    end

    // Sign correction of the magnitude results
    assign prod   = {hi, lo};
    assign prod_s = neg_q ? -prod : prod;
    assign quo    = neg_q ? -lo : lo;
    assign rem    = neg_q ? -hi : hi;

    always_comb begin
        case (op_q)
            MD_MUL:                       result = prod_s[XW-1:0];
            MD_MULH, MD_MULHSU, MD_MULHU: result = prod_s[2*XW-1:XW];
            // Divide by zero gives all ones, the remainder is already rs1
            MD_DIV, MD_DIVU:              result = div_zero_q ? '1 : quo;
            default:                      result = rem;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_execute (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         instr_valid,
    input  wire rv_exec_pkg::rv_instr_t instr,
    input  wire  [`RV_XLEN-1:0]         pc,
    input  wire  [`RV_XLEN-1:0]         rs1_data,
    input  wire  [`RV_XLEN-1:0]         rs2_data,
    output logic                        instr_ready,
    output logic                        rd_write,
    output logic [4:0]                  rd_addr,
    output logic [`RV_XLEN-1:0]         rd_wdata,
    output logic                        branch_taken,
    output logic [`RV_XLEN-1:0]         branch_target,
    output logic                        illegal
);
    import rv_exec_pkg::*;

    op_class_e           op_class;
    alu_op_e             alu_op;
    logic                alu_use_imm;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] alu_result;
    logic                br_cond;
    logic                br_bad;
    logic                md_start;
    logic                md_done;
    logic [`RV_XLEN-1:0] md_result;

    logic                br_calc;
    logic                br_taken_q;
    logic                md_busy;
    logic                wb_en;

    assign rd_addr = instr.r.rd;

    rv_decoder u_decoder (
        .instr(instr), .op_class(op_class), .alu_op(alu_op), .alu_use_imm(alu_use_imm),
        .imm_i(imm_i), .imm_u(imm_u), .imm_b(imm_b), .imm_j(imm_j)
    );

    rv_alu u_alu (
        .alu_op(alu_op), .a(rs1_data), .b(alu_use_imm ? imm_i : rs2_data),
        .result(alu_result)
    );

    rv_branch_unit u_branch (
        .funct3(instr.b.funct3), .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc),
        .imm_b(imm_b), .imm_j(imm_j), .imm_i(imm_i), .op_class(op_class),
        .taken(br_cond), .target(branch_target), .bad_cond(br_bad)
    );

    rv_muldiv u_muldiv (
        .clk(clk), .rst_n(rst_n), .start(md_start), .md_op(md_op_e'(instr.r.funct3)),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .done(md_done), .result(md_result)
    );

    always_comb begin
        instr_ready  = 1'b1;
        wb_en        = 1'b0;
        branch_taken = 1'b0;
        illegal      = 1'b0;
        md_start     = 1'b0;
        if (instr_valid) begin
            case (op_class)
                CLASS_ALU, CLASS_LUI, CLASS_AUIPC: wb_en = 1'b1;
                CLASS_JAL, CLASS_JALR: begin
                    wb_en        = 1'b1;
                    branch_taken = 1'b1;
                end
                CLASS_BRANCH: begin
                    // Compare is registered first, committed next cycle
                    if (br_bad)
                        illegal = 1'b1;
                    else if (!br_calc)
                        instr_ready = 1'b0;
                    else
                        branch_taken = br_taken_q;
                end
                CLASS_MULDIV: begin
                    md_start    = !md_busy;
                    instr_ready = md_done;
                    wb_en       = md_done;
                end
                default: illegal = 1'b1;
            endcase
        end
    end

    assign rd_write = wb_en && (rd_addr != 5'd0);

    always_comb begin
        case (op_class)
            CLASS_LUI:             rd_wdata = imm_u;
            CLASS_AUIPC:           rd_wdata = pc + imm_u;
            CLASS_JAL, CLASS_JALR: rd_wdata = pc + `RV_XLEN'd4;
            CLASS_MULDIV:          rd_wdata = md_result;
            default:               rd_wdata = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            br_calc <= 1'b0;
            md_busy <= 1'b0;
        end else begin
            if (instr_valid && op_class == CLASS_BRANCH && !br_bad)
                br_calc <= !br_calc;
            if (md_start)
                md_busy <= 1'b1;
            else if (md_done)
                md_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!br_calc)
            br_taken_q <= br_cond;
    end

endmodule

`default_nettype wire

//--- sim/rv_execute_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute_chk (
    input wire       clk,
    input wire       rst_n,
    input wire       instr_valid,
    input wire       instr_ready,
    input wire       rd_write,
    input wire [4:0] rd_addr,
    input wire       branch_taken,
    input wire       illegal
);

    // Write-back only in the acceptance cycle
    a_write_accepted: assert property (@(posedge clk) disable iff (!rst_n)
        rd_write |-> (instr_valid && instr_ready))
        else $error("rd_write high without an accepted instruction");

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        rd_write |-> (rd_addr != 5'd0))
        else $error("rd_write high for register zero");

    a_illegal_alone: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> (!rd_write && !branch_taken))
        else $error("illegal together with a write-back or a redirect");

    // Idle stage ready right after reset
    a_ready_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> instr_ready)
        else $error("instr_ready low in the first cycle after reset");

endmodule

bind rv_execute rv_execute_chk u_chk (
    .clk(clk),
    .rst_n(rst_n),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .rd_write(rd_write),
    .rd_addr(rd_addr),
    .branch_taken(branch_taken),
    .illegal(illegal)
);

`default_nettype wire

//--- sim/rv_execute_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_macros.svh"

module rv_execute_tb;

    localparam int TIMEOUT_CYCLES = 100;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        instr_ready;
    logic        rd_write;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        illegal;

    // One entry per index across all queues
    string       name_q[$];
    logic [31:0] instr_q[$];
    logic [31:0] pc_q[$];
    logic [31:0] rs1_q[$];
    logic [31:0] rs2_q[$];
    logic        write_q[$];
    logic [4:0]  rd_q[$];
    logic [31:0] wdata_q[$];
    logic        taken_q[$];
    logic [31:0] target_q[$];
    logic        chk_tgt_q[$];
    logic        illegal_q[$];

    rv_execute u_dut (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .instr_ready(instr_ready),
        .rd_write(rd_write), .rd_addr(rd_addr), .rd_wdata(rd_wdata),
        .branch_taken(branch_taken), .branch_target(branch_target), .illegal(illegal)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Encoders follow the base ISA field layout
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, `RV_OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], `RV_OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OPC_JAL};
    endfunction

    task automatic add_case(input string name, input logic [31:0] ins, input logic [31:0] pc_v,
                            input logic [31:0] a, input logic [31:0] b, input logic wr,
                            input logic [4:0] rd, input logic [31:0] wdata, input logic tk,
                            input logic [31:0] tgt, input logic chk_tgt, input logic ill);
        name_q.push_back(name);
        instr_q.push_back(ins);
        pc_q.push_back(pc_v);
        rs1_q.push_back(a);
        rs2_q.push_back(b);
        write_q.push_back(wr);
        rd_q.push_back(rd);
        wdata_q.push_back(wdata);
        taken_q.push_back(tk);
        target_q.push_back(tgt);
        chk_tgt_q.push_back(chk_tgt);
        illegal_q.push_back(ill);
    endtask

    task automatic add_wb(input string name, input logic [31:0] ins, input logic [4:0] rd,
                          input logic [31:0] pc_v, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] wdata);
        add_case(name, ins, pc_v, a, b, 1'b1, rd, wdata, 1'b0, 32'd0, 1'b0, 1'b0);
    endtask

    task automatic add_md(input string name, input logic [2:0] f3, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] wdata);
        add_wb(name, enc_r(`RV_F7_MULDIV, f3, 5'd10), 5'd10, 32'h0, a, b, wdata);
    endtask

    // Jumps link pc + 4 and always redirect
    task automatic add_jump(input string name, input logic [31:0] ins, input logic [4:0] rd,
                            input logic [31:0] pc_v, input logic [31:0] a,
                            input logic [31:0] tgt);
        add_case(name, ins, pc_v, a, 32'd0, 1'b1, rd, pc_v + 32'd4, 1'b1, tgt, 1'b1, 1'b0);
    endtask

    task automatic add_branch(input string name, input logic [2:0] f3, input logic [31:0] a,
                              input logic [31:0] b, input logic tk);
        add_case(name, enc_b(13'h0040, f3), 32'h400, a, b, 1'b0, 5'd0, 32'd0, tk, 32'h440,
                 1'b1, 1'b0);
    endtask

    task automatic add_illegal(input string name, input logic [31:0] ins);
        add_case(name, ins, 32'h800, 32'd1, 32'd2, 1'b0, 5'd0, 32'd0, 1'b0, 32'd0,
                 1'b0, 1'b1);
    endtask

    task automatic build_table;
        add_wb("add", enc_r(`RV_F7_BASE, 3'd0, 5'd5), 5'd5, 32'h0, 32'h10, 32'h22,
               32'h32);
        add_wb("sub", enc_r(`RV_F7_ALT, 3'd0, 5'd6), 5'd6, 32'h0, 32'd5, 32'd7,
               32'hFFFFFFFE);
        add_wb("slt", enc_r(`RV_F7_BASE, 3'd2, 5'd7), 5'd7, 32'h0, 32'hFFFFFFFF, 32'd1,
               32'd1);
        add_wb("sltu", enc_r(`RV_F7_BASE, 3'd3, 5'd7), 5'd7, 32'h0, 32'hFFFFFFFF, 32'd1,
               32'd0);
        add_wb("sra", enc_r(`RV_F7_ALT, 3'd5, 5'd8), 5'd8, 32'h0, 32'h80000010, 32'd4,
               32'hF8000001);
        add_wb("andi", enc_i(12'h0F0, 3'd7, 5'd9, `RV_OPC_OP_IMM), 5'd9, 32'h0, 32'h12345678,
               32'd0, 32'h70);
        add_wb("addi_neg", enc_i(12'hFFF, 3'd0, 5'd9, `RV_OPC_OP_IMM), 5'd9, 32'h0, 32'h100,
               32'd0, 32'hFF);
        add_wb("srai", enc_i(12'h408, 3'd5, 5'd9, `RV_OPC_OP_IMM), 5'd9, 32'h0, 32'h80000000,
               32'd0, 32'hFF800000);
        add_wb("lui", enc_u(20'h12345, 5'd7, `RV_OPC_LUI), 5'd7, 32'h0, 32'd0, 32'd0,
               32'h12345000);
        add_wb("auipc", enc_u(20'hFFFFF, 5'd7, `RV_OPC_AUIPC), 5'd7, 32'h3000, 32'd0, 32'd0,
               32'h2000);
        add_case("add_x0", enc_r(`RV_F7_BASE, 3'd0, 5'd0), 32'h0, 32'd1, 32'd2, 1'b0, 5'd0,
                 32'd0, 1'b0, 32'd0, 1'b0, 1'b0);
        add_jump("jal", enc_j(21'h000020, 5'd1), 5'd1, 32'h100, 32'd0, 32'h120);
        add_jump("jal_back", enc_j(21'h1FFFF0, 5'd1), 5'd1, 32'h2000, 32'd0, 32'h1FF0);
        add_jump("jalr", enc_i(12'h010, 3'd0, 5'd1, `RV_OPC_JALR), 5'd1, 32'h500, 32'h3001,
                 32'h3010);
        add_jump("jalr_neg", enc_i(12'hFFD, 3'd0, 5'd1, `RV_OPC_JALR), 5'd1, 32'h600,
                 32'h4000, 32'h3FFC);
        add_branch("beq_t", 3'd0, 32'd5, 32'd5, 1'b1);
        add_branch("beq_n", 3'd0, 32'd5, 32'd6, 1'b0);
        add_branch("bne_t", 3'd1, 32'd5, 32'd6, 1'b1);
        add_branch("bne_n", 3'd1, 32'd5, 32'd5, 1'b0);
        add_branch("blt_t", 3'd4, 32'hFFFFFFFF, 32'd1, 1'b1);
        add_branch("blt_n", 3'd4, 32'd1, 32'hFFFFFFFF, 1'b0);
        add_branch("bge_t", 3'd5, 32'd1, 32'hFFFFFFFF, 1'b1);
        add_branch("bge_n", 3'd5, 32'hFFFFFFFF, 32'd1, 1'b0);
        add_branch("bltu_t", 3'd6, 32'd1, 32'hFFFFFFFF, 1'b1);
        add_branch("bltu_n", 3'd6, 32'hFFFFFFFF, 32'd1, 1'b0);
        add_branch("bgeu_t", 3'd7, 32'hFFFFFFFF, 32'd1, 1'b1);
        add_branch("bgeu_n", 3'd7, 32'd1, 32'hFFFFFFFF, 1'b0);
        add_case("beq_back", enc_b(13'h1FF8, 3'd0), 32'h400, 32'd3, 32'd3, 1'b0, 5'd0, 32'd0,
                 1'b1, 32'h3F8, 1'b1, 1'b0);
        add_md("mul", 3'd0, 32'hFFFFFFFE, 32'd3, 32'hFFFFFFFA);
        add_md("mul_pos", 3'd0, 32'h12345678, 32'h10, 32'h23456780);
        add_md("mulh", 3'd1, 32'hFFFFFFFE, 32'h80000000, 32'h00000001);
        add_md("mulhsu", 3'd2, 32'hFFFFFFFE, 32'h80000000, 32'hFFFFFFFF);
        add_md("mulhu", 3'd3, 32'hFFFFFFFE, 32'h80000000, 32'h7FFFFFFF);
        add_md("div", 3'd4, 32'hFFFFFFF9, 32'd2, 32'hFFFFFFFD);
        add_md("div_negb", 3'd4, 32'd20, 32'hFFFFFFFA, 32'hFFFFFFFD);
        add_md("divu", 3'd5, 32'hFFFFFFF9, 32'd2, 32'h7FFFFFFC);
        add_md("rem", 3'd6, 32'hFFFFFFF9, 32'd2, 32'hFFFFFFFF);
        add_md("rem_negb", 3'd6, 32'd20, 32'hFFFFFFFA, 32'd2);
        add_md("remu", 3'd7, 32'hFFFFFFF9, 32'd2, 32'd1);
        add_md("div_zero", 3'd4, 32'd5, 32'd0, 32'hFFFFFFFF);
        add_md("divu_zero", 3'd5, 32'd5, 32'd0, 32'hFFFFFFFF);
        add_md("rem_zero", 3'd6, 32'hFFFFFFF9, 32'd0, 32'hFFFFFFF9);
        add_md("remu_zero", 3'd7, 32'd5, 32'd0, 32'd5);
        add_md("div_ovf", 3'd4, 32'h80000000, 32'hFFFFFFFF, 32'h80000000);
        add_md("rem_ovf", 3'd6, 32'h80000000, 32'hFFFFFFFF, 32'd0);
        add_illegal("load_opc", enc_i(12'h0, 3'd2, 5'd3, 7'b0000011));
        add_illegal("sll_alt_f7", enc_r(7'b0100000, 3'd1, 5'd4));
        add_illegal("bad_f7", enc_r(7'b1111111, 3'd0, 5'd4));
        add_illegal("branch_f3_2", enc_b(13'h0040, 3'd2));
        add_illegal("jalr_f3_1", enc_i(12'h0, 3'd1, 5'd1, `RV_OPC_JALR));
    endtask

    task automatic stop_with_failure;
        $display("Checks failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("Fail %s: %s expected 0x%08h, actual 0x%08h", name, field, exp, act);
            stop_with_failure();
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic run_case(input int idx);
        int    waited;
        string name;
        name        = name_q[idx];
        instr_valid = 1'b1;
        instr       = instr_q[idx];
        pc          = pc_q[idx];
        rs1_data    = rs1_q[idx];
        rs2_data    = rs2_q[idx];
        waited      = 0;
        #1;
        while (!instr_ready && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            #1;
            waited++;
        end
        assert (instr_ready)
        else begin
            $display("Timeout in test %s: instr_ready stayed low for %0d cycles",
                     name, TIMEOUT_CYCLES);
            stop_with_failure();
        end
        check_value(name, "rd_write", 32'(write_q[idx]), 32'(rd_write));
        check_value(name, "branch_taken", 32'(taken_q[idx]), 32'(branch_taken));
        check_value(name, "illegal", 32'(illegal_q[idx]), 32'(illegal));
        if (write_q[idx]) begin
            check_value(name, "rd_addr", 32'(rd_q[idx]), 32'(rd_addr));
            check_value(name, "rd_wdata", wdata_q[idx], rd_wdata);
        end
        if (chk_tgt_q[idx])
            check_value(name, "branch_target", target_q[idx], branch_target);
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    initial begin
        int idle;
        void'($urandom(26788));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        pc          = 32'd0;
        rs1_data    = 32'd0;
        rs2_data    = 32'd0;
        build_table();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < name_q.size(); i++) begin
            idle = int'($urandom % 4);
            repeat (idle) @(negedge clk);
            run_case(i);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/rv_exec_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_branch_unit.sv
design/rv_muldiv.sv
design/rv_execute.sv
sim/rv_execute_chk.sv
sim/rv_execute_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    -f build.f --top-module rv_execute_tb --Mdir "$OBJ_DIR" -o rv_execute_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ_DIR/rv_execute_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
